// File: filelist.f
+incdir+include
src/pixel_pkg.sv
src/upsample_ctrl_pkg.sv
src/feature_map_buffer.sv
src/upsample_addr_gen.sv
src/upsample_ctrl.sv
src/pixel_emit.sv
src/cnn_upsampling_nn.sv
test/tb_upsampling.sv

// File: Bender.yml
package:
  name: cnn_upsampling_nn

sources:
  - include_dirs:
      - include
    files:
      - src/pixel_pkg.sv
      - src/upsample_ctrl_pkg.sv
      - src/feature_map_buffer.sv
      - src/upsample_addr_gen.sv
      - src/upsample_ctrl.sv
      - src/pixel_emit.sv
      - src/cnn_upsampling_nn.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_upsampling.sv

// File: test/tb_upsampling.sv
`include "upsample_config.svh"

module tb_upsampling;

	timeunit 1ns;
	timeprecision 1ps;

	// Output pixels per frame
	localparam int RUN = `UPS_FRAME_PIXELS * `UPS_SCALE * `UPS_SCALE;
	// Output row length
	localparam int OUT_WIDTH = `UPS_IMAGE_WIDTH * `UPS_SCALE;
	localparam int OUT_HEIGHT = `UPS_IMAGE_HEIGHT * `UPS_SCALE;
	// Cycles allowed for load gaps, emission and drain
	localparam int DONE_LIMIT = RUN + 8 * `UPS_FRAME_PIXELS + 64;

	logic              clk;
	logic              reset;
	logic              valid_in;
	pixel_pkg::pixel_t pxl_in;
	pixel_pkg::pixel_t pxl_out;
	logic              valid_out;
	logic              frame_done;

	// Copy of the frame as it was loaded
	pixel_pkg::pixel_t model [`UPS_FRAME_PIXELS];
	pixel_pkg::pixel_t expected_pxl;

	// Output bookkeeping
	int out_idx;
	int run_len;
	int frames_seen;
	int out_col;
	int out_row;
	int out_chan;

	// High while the DUT must stay quiet
	logic awaiting_frame;

	logic [31:0] rng_state = 32'hfb72_6250;

	cnn_upsampling_nn u_dut (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out),
		.frame_done (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////
	// Helpers
	//////////////////////

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic stop_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		stop_with_failure();
	endtask

	// One pixel per strobe, optional idle cycles in between
	task automatic send_frame(input bit with_gaps);
		int gap;
		pixel_pkg::pixel_t pix;
		for (int i = 0; i < `UPS_FRAME_PIXELS; i++) begin
			if (with_gaps) begin
				gap = int'(next_rand() % 4);
				repeat (gap) begin
					valid_in = 1'b0;
					@(posedge clk);
					#1;
				end
			end
			pix = pixel_pkg::pixel_t'(next_rand());
			model[i] = pix;
			valid_in = 1'b1;
			pxl_in = pix;
			@(posedge clk);
			#1;
		end
		valid_in = 1'b0;
		awaiting_frame = 1'b0;
	endtask

	// Random strobes that the DUT has to drop
	task automatic inject_junk(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			valid_in = (next_rand() % 2) == 1;
			pxl_in = pixel_pkg::pixel_t'(next_rand());
			@(posedge clk);
			#1;
		end
		valid_in = 1'b0;
	endtask

	task automatic wait_frame_done(input string which);
		int cycles;
		cycles = 0;
		while (frame_done !== 1'b1) begin
			if (cycles >= DONE_LIMIT) begin
				report_problem({"timeout waiting for frame_done of ", which});
			end
			@(posedge clk);
			#1;
			cycles++;
		end
	endtask

	//////////////////////
	// Reference model
	//////////////////////

	always_comb begin
		out_col = out_idx % OUT_WIDTH;
		out_row = (out_idx / OUT_WIDTH) % OUT_HEIGHT;
		out_chan = out_idx / (`UPS_IMAGE_SIZE * `UPS_SCALE * `UPS_SCALE);
		expected_pxl = '0;
		// Past the end of the frame nothing is compared
		if (out_chan < `UPS_CHANNEL_NUM) begin
			expected_pxl = model[out_chan * `UPS_IMAGE_SIZE
				+ (out_row / `UPS_SCALE) * `UPS_IMAGE_WIDTH
				+ out_col / `UPS_SCALE];
		end
	end

	// Output index and length of the current valid run
	always @(posedge clk) begin
		if (reset) begin
			out_idx <= 0;
			run_len <= 0;
			frames_seen <= 0;
		end else begin
			run_len <= valid_out ? run_len + 1 : 0;
			if (frame_done) begin
				out_idx <= 0;
				frames_seen <= frames_seen + 1;
			end else if (valid_out) begin
				out_idx <= out_idx + 1;
			end
		end
	end

	//////////////////////
	// Checks
	//////////////////////

	a_quiet_while_loading: assert property (
		@(posedge clk) disable iff (reset) awaiting_frame |-> !valid_out && !frame_done
	) else report_problem("output activity before a whole frame was loaded");

	// Covers column repeat, row repeat and channel order
	a_pixel_value: assert property (
		@(posedge clk) disable iff (reset) valid_out |-> pxl_out == expected_pxl
	) else report_mismatch("pxl_out", $sampled(pxl_out), $sampled(expected_pxl));

	a_run_not_too_long: assert property (
		@(posedge clk) disable iff (reset) valid_out |-> run_len < RUN
	) else report_problem("valid_out stayed high longer than one frame of output");

	a_run_full_length: assert property (
		@(posedge clk) disable iff (reset) $fell(valid_out) |-> run_len == RUN
	) else report_mismatch("valid_out run length", $sampled(run_len), RUN);

	// Done follows the last output directly
	a_done_after_last: assert property (
		@(posedge clk) disable iff (reset) $fell(valid_out) |-> frame_done
	) else report_problem("frame_done missing in the cycle after the last output");

	a_done_count: assert property (
		@(posedge clk) disable iff (reset) frame_done |-> out_idx == RUN
	) else report_mismatch("output count at frame_done", $sampled(out_idx), RUN);

	a_done_single: assert property (
		@(posedge clk) disable iff (reset) frame_done |=> !frame_done
	) else report_problem("frame_done was wider than one cycle");

	//////////////////////
	// Stimulus
	//////////////////////

	initial begin
		reset = 1'b1;
		valid_in = 1'b0;
		pxl_in = '0;
		awaiting_frame = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// Frame one back to back, junk during emission
		send_frame(1'b0);
		inject_junk(300);
		wait_frame_done("frame one");

		// DONE cycle drops strobes, start one cycle later
		@(posedge clk);
		#1;
		awaiting_frame = 1'b1;

		// Frame two with random gaps
		send_frame(1'b1);
		inject_junk(150);
		wait_frame_done("frame two");

		@(posedge clk);
		#1;
		if (frames_seen == 2) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			report_problem("frame_done count differs from two frames");
		end
	end

endmodule

// File: src/cnn_upsampling_nn.sv
module cnn_upsampling_nn (
	input  logic               clk,
	input  logic               reset,
	input  logic               valid_in,
	input  pixel_pkg::pixel_t  pxl_in,
	output pixel_pkg::pixel_t  pxl_out,
	output logic               valid_out,
	output logic               frame_done
);

	// Controller and buffer
	logic wr_en;
	logic clear;
	logic full;

	// Controller and read sequencer
	logic start;
	logic last;

	// Read path
	logic              rd_en;
	pixel_pkg::addr_t  rd_addr;
	pixel_pkg::pixel_t rd_data;

	upsample_ctrl u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.full       (full),
		.last       (last),
		.wr_en      (wr_en),
		.clear      (clear),
		.start      (start),
		.frame_done (frame_done)
	);

	feature_map_buffer u_buffer (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_data (pxl_in),
		.clear   (clear),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.full    (full)
	);

	upsample_addr_gen u_addr_gen (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.last    (last)
	);

	// Two cycles from read strobe to output
	pixel_emit u_emit (
		.clk       (clk),
		.reset     (reset),
		.rd_en     (rd_en),
		.rd_data   (rd_data),
		.pxl_out   (pxl_out),
		.valid_out (valid_out)
	);

endmodule

// File: src/pixel_emit.sv
module pixel_emit (
	input  logic               clk,
	input  logic               reset,
	input  logic               rd_en,
	input  pixel_pkg::pixel_t  rd_data,
	output pixel_pkg::pixel_t  pxl_out,
	output logic               valid_out
);

	// Read strobe lined up with buffer output
	logic rd_en_d;

	//////////////////////
	// Valid pipeline
	//////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_en_d   <= 1'b0;
			valid_out <= 1'b0;
		end else begin
			rd_en_d   <= rd_en;
			valid_out <= rd_en_d;
		end
	end

	// Data register, keeps the previous value between frames
	always_ff @(posedge clk) begin
		if (rd_en_d) begin
			pxl_out <= rd_data;
		end
	end

endmodule

// File: src/upsample_ctrl.sv
module upsample_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic valid_in,
	input  logic full,
	input  logic last,
	output logic wr_en,
	output logic clear,
	output logic start,
	output logic frame_done
);

	upsample_ctrl_pkg::ctrl_state_t state;
	upsample_ctrl_pkg::ctrl_state_t state_next;

	// Counts the two read pipeline cycles
	logic drain_cnt;

	//////////////////////
	// Next state
	//////////////////////

	always_comb begin
		state_next = state;
		case (state)
			upsample_ctrl_pkg::ST_LOAD: begin
				if (full) begin
					state_next = upsample_ctrl_pkg::ST_EMIT;
				end
			end
			upsample_ctrl_pkg::ST_EMIT: begin
				// Final read issued this cycle
				if (last) begin
					state_next = upsample_ctrl_pkg::ST_DRAIN;
				end
			end
			upsample_ctrl_pkg::ST_DRAIN: begin
				if (drain_cnt) begin
					state_next = upsample_ctrl_pkg::ST_DONE;
				end
			end
			default: begin
				state_next = upsample_ctrl_pkg::ST_LOAD;
			end
		endcase
	end

	//////////////////////
	// State registers
	//////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= upsample_ctrl_pkg::ST_LOAD;
			drain_cnt <= 1'b0;
			start     <= 1'b0;
		end else begin
			state <= state_next;
			// Only advances while draining
			drain_cnt <= (state == upsample_ctrl_pkg::ST_DRAIN) ? ~drain_cnt : 1'b0;
			// High in the first cycle of ST_EMIT
			start <= (state == upsample_ctrl_pkg::ST_LOAD) && full;
		end
	end

	// Strobes outside loading are dropped, as is the gap cycle after full
	assign wr_en = valid_in && (state == upsample_ctrl_pkg::ST_LOAD) && !full;

	// Frame end also rewinds the buffer pointer
	assign frame_done = (state == upsample_ctrl_pkg::ST_DONE);
	assign clear      = frame_done;

	// Read sequencer may only finish a frame while emitting
	a_last_only_in_emit: assert property (
		@(posedge clk) disable iff (reset) last |-> state == upsample_ctrl_pkg::ST_EMIT
	);

endmodule

// File: src/upsample_addr_gen.sv
`include "upsample_config.svh"

module upsample_addr_gen (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	output logic              rd_en,
	output pixel_pkg::addr_t  rd_addr,
	output logic              last
);

	// Sequencer running after the start cycle
	logic busy;

	// Counters, innermost first
	pixel_pkg::rep_t  col_rep;
	pixel_pkg::col_t  col;
	pixel_pkg::rep_t  row_rep;
	pixel_pkg::row_t  row;
	pixel_pkg::chan_t chan;

	// Each counter at its final value
	logic col_rep_wrap;
	logic col_wrap;
	logic row_rep_wrap;
	logic row_wrap;
	logic chan_wrap;

	assign col_rep_wrap = (col_rep == pixel_pkg::rep_t'(`UPS_SCALE - 1));
	assign col_wrap     = (col == pixel_pkg::col_t'(`UPS_IMAGE_WIDTH - 1));
	assign row_rep_wrap = (row_rep == pixel_pkg::rep_t'(`UPS_SCALE - 1));
	assign row_wrap     = (row == pixel_pkg::row_t'(`UPS_IMAGE_HEIGHT - 1));
	assign chan_wrap    = (chan == pixel_pkg::chan_t'(`UPS_CHANNEL_NUM - 1));

	// First read goes out in the start cycle itself
	assign rd_en = start | busy;

	// Final repeat of the final pixel of the final channel
	assign last = rd_en & col_rep_wrap & col_wrap & row_rep_wrap & row_wrap & chan_wrap;

	//////////////////////
	// Address from source coordinates
	//////////////////////

	// Repeat counters do not enter the address
	assign rd_addr = pixel_pkg::addr_t'(chan) * pixel_pkg::addr_t'(`UPS_IMAGE_SIZE)
		+ pixel_pkg::addr_t'(row) * pixel_pkg::addr_t'(`UPS_IMAGE_WIDTH)
		+ pixel_pkg::addr_t'(col);

	//////////////////////
	// Counter chain
	//////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			col_rep <= '0;
			col     <= '0;
			row_rep <= '0;
			row     <= '0;
			chan    <= '0;
		end else begin
			if (start) begin
				busy <= 1'b1;
			end
			// Sequence ends, counters are back at zero
			if (last) begin
				busy <= 1'b0;
			end
			if (rd_en) begin
				col_rep <= col_rep_wrap ? '0 : col_rep + 1'b1;
				if (col_rep_wrap) begin
					col <= col_wrap ? '0 : col + 1'b1;
					// End of a row, send it again or move on
					if (col_wrap) begin
						row_rep <= row_rep_wrap ? '0 : row_rep + 1'b1;
						if (row_rep_wrap) begin
							row <= row_wrap ? '0 : row + 1'b1;
							// Plane finished
							if (row_wrap) begin
								chan <= chan_wrap ? '0 : chan + 1'b1;
							end
						end
					end
				end
			end
		end
	end

	// A new frame may only launch once the previous one has run out
	a_no_start_while_busy: assert property (
		@(posedge clk) disable iff (reset) start |-> !busy
	);

endmodule

// File: src/feature_map_buffer.sv
`include "upsample_config.svh"

module feature_map_buffer (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr_en,
	input  pixel_pkg::pixel_t  wr_data,
	input  logic               clear,
	input  logic               rd_en,
	input  pixel_pkg::addr_t   rd_addr,
	output pixel_pkg::pixel_t  rd_data,
	output logic               full
);

	// Whole frame, channel-major then row-major
	pixel_pkg::pixel_t mem [`UPS_FRAME_PIXELS];

	// Next free slot
	pixel_pkg::addr_t wr_ptr;

	//////////////////////
	// Write side
	//////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Pointer and full flag, cleared between frames
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			full   <= 1'b0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
			// Last slot of the frame written
			if (wr_ptr == pixel_pkg::addr_t'(`UPS_FRAME_PIXELS - 1)) begin
				full <= 1'b1;
			end
		end
	end

	//////////////////////
	// Read side
	//////////////////////

	// One cycle read latency
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	// Controller must stop writes once the frame is complete
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (reset) full |-> !wr_en
	);

endmodule

// File: src/upsample_ctrl_pkg.sv
package upsample_ctrl_pkg;

	//////////////////////
	// Frame controller states
	//////////////////////

	typedef enum logic [1:0] {
		// Taking pixels into the buffer
		ST_LOAD,
		// Read sequencer running
		ST_EMIT,
		// Last reads still in the pipeline
		ST_DRAIN,
		// Single cycle, frame finished
		ST_DONE
	} ctrl_state_t;

endpackage

// File: src/pixel_pkg.sv
`include "upsample_config.svh"

package pixel_pkg;

	// One feature map value
	typedef logic [`UPS_DATA_WIDTH-1:0] pixel_t;

	// Linear index into the frame buffer
	typedef logic [`UPS_ADDR_WIDTH-1:0] addr_t;

	// Source coordinates inside a channel plane
	typedef logic [`UPS_ROW_WIDTH-1:0] row_t;
	typedef logic [`UPS_COL_WIDTH-1:0] col_t;

	// Channel index within the frame
	typedef logic [`UPS_CHAN_WIDTH-1:0] chan_t;

	// Repeat count, 0 up to scale minus one
	typedef logic [`UPS_REP_WIDTH-1:0] rep_t;

endpackage

// File: include/upsample_config.svh
`ifndef UPSAMPLE_CONFIG_SVH
`define UPSAMPLE_CONFIG_SVH

//////////////////////
// Source image geometry
//////////////////////

// Width of one channel in pixels
`define UPS_IMAGE_WIDTH 8
// Height of one channel in rows
`define UPS_IMAGE_HEIGHT 8
// Channels per frame
`define UPS_CHANNEL_NUM 2

// Repeat factor on each axis
`define UPS_SCALE 4
// Bits per pixel word
`define UPS_DATA_WIDTH 16

//////////////////////
// Derived sizes
//////////////////////

// Pixels in one channel plane
`define UPS_IMAGE_SIZE (`UPS_IMAGE_WIDTH * `UPS_IMAGE_HEIGHT)
// Pixels in a whole frame
`define UPS_FRAME_PIXELS (`UPS_IMAGE_SIZE * `UPS_CHANNEL_NUM)
// Address bits for the frame buffer
`define UPS_ADDR_WIDTH ($clog2(`UPS_FRAME_PIXELS))

// Counter widths for the read sequencer
`define UPS_COL_WIDTH ($clog2(`UPS_IMAGE_WIDTH))
`define UPS_ROW_WIDTH ($clog2(`UPS_IMAGE_HEIGHT))
`define UPS_CHAN_WIDTH ($clog2(`UPS_CHANNEL_NUM))
`define UPS_REP_WIDTH ($clog2(`UPS_SCALE))

`endif
